/* rtl/dm_cfg.svh */
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// --------------------------------------------------
// System size
// --------------------------------------------------

// Four tiles in a 2x2 arrangement.
`define DM_NUM_TILES 4

// --------------------------------------------------
// Tile memory
// --------------------------------------------------

`define DM_MEM_WORDS 64  // Words per tile memory.
`define DM_DATA_W    32  // Bits per data word.

`endif

/* rtl/dm_pkg.sv */
`default_nettype none

`include "dm_cfg.svh"

package dm_pkg;

   // Field widths derived from the system size.
   localparam int TILE_W = $clog2(`DM_NUM_TILES);
   localparam int ADDR_W = $clog2(`DM_MEM_WORDS);

   typedef logic [TILE_W-1:0]     tile_id_t;   // Tile number.
   typedef logic [ADDR_W-1:0]     mem_addr_t;  // Word address in one tile.
   typedef logic [`DM_DATA_W-1:0] word_t;      // Data word.

   // Shared by the host command port and the memory bus.
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } bus_op_e;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,  // Ready for a host command.
      ST_REQ  = 2'd1,  // Bus request pending.
      ST_WAIT = 2'd2   // Waiting for read data.
   } tile_state_e;

endpackage

`default_nettype wire

/* rtl/dm_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dm_bus_if
   import dm_pkg::*;
();

   // --------------------------------------------------
   // Master side of one tile
   // --------------------------------------------------
   logic      req;     // Access request.
   bus_op_e   op;      // Read or write.
   tile_id_t  dst;     // Destination tile.
   mem_addr_t addr;    // Word address in destination.
   word_t     wdata;   // Write data.
   logic      gnt;     // Request taken this cycle.
   logic      rvalid;  // Read data return.
   word_t     rdata;

   // --------------------------------------------------
   // Slave side, into this tile's memory
   // --------------------------------------------------
   logic      s_stb;
   bus_op_e   s_op;
   mem_addr_t s_addr;
   word_t     s_wdata;
   word_t     s_rdata; // Valid the cycle after a read strobe.

   modport master (output req, op, dst, addr, wdata,
                   input  gnt, rvalid, rdata);

   modport slave  (input  s_stb, s_op, s_addr, s_wdata,
                   output s_rdata);

   modport arb    (input  req, op, dst, addr, wdata, s_rdata,
                   output gnt, rvalid, rdata, s_stb, s_op, s_addr, s_wdata);

endinterface

`default_nettype wire

/* rtl/mem_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module mem_bus_arbiter
   import dm_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n_i,
   dm_bus_if.arb bus_if [`DM_NUM_TILES-1:0]
);

   logic [`DM_NUM_TILES-1:0] req;
   logic [`DM_NUM_TILES-1:0] gnt;
   bus_op_e                  op      [`DM_NUM_TILES];
   tile_id_t                 dst     [`DM_NUM_TILES];
   mem_addr_t                addr    [`DM_NUM_TILES];
   word_t                    wdata   [`DM_NUM_TILES];
   word_t                    s_rdata [`DM_NUM_TILES];

   tile_id_t  ptr_q;      // Highest priority tile.
   logic      gnt_any;
   tile_id_t  gnt_idx;
   tile_id_t  cand;
   bus_op_e   fwd_op;
   tile_id_t  fwd_dst;
   mem_addr_t fwd_addr;
   word_t     fwd_wdata;
   logic      rd_pend_q;  // Read granted last cycle.
   tile_id_t  rd_idx_q;   // Master waiting for data.
   tile_id_t  rd_src_q;   // Slave holding the data.
   word_t     rd_data;

   // --------------------------------------------------
   // Per-tile port mapping
   // --------------------------------------------------
   for (genvar g = 0; g < `DM_NUM_TILES; g++) begin : gen_port
      assign req[g]     = bus_if[g].req;
      assign op[g]      = bus_if[g].op;
      assign dst[g]     = bus_if[g].dst;
      assign addr[g]    = bus_if[g].addr;
      assign wdata[g]   = bus_if[g].wdata;
      assign s_rdata[g] = bus_if[g].s_rdata;

      assign gnt[g]            = gnt_any && (gnt_idx == tile_id_t'(g));
      assign bus_if[g].gnt     = gnt[g];
      assign bus_if[g].s_stb   = gnt_any && (fwd_dst == tile_id_t'(g));
      assign bus_if[g].s_op    = fwd_op;
      assign bus_if[g].s_addr  = fwd_addr;
      assign bus_if[g].s_wdata = fwd_wdata;
      assign bus_if[g].rvalid  = rd_pend_q && (rd_idx_q == tile_id_t'(g));
      assign bus_if[g].rdata   = rd_data;
   end

   // --------------------------------------------------
   // Round-robin pick and field steering
   // --------------------------------------------------
   always_comb begin
      gnt_any = 1'b0;
      gnt_idx = ptr_q;
      cand    = ptr_q;
      for (int k = 0; k < `DM_NUM_TILES; k++) begin
         cand = tile_id_t'((int'(ptr_q) + k) % `DM_NUM_TILES);
         if (!gnt_any && req[cand]) begin
            gnt_any = 1'b1;  // First requester after the pointer.
            gnt_idx = cand;
         end
      end
      fwd_op    = op[gnt_idx];
      fwd_dst   = dst[gnt_idx];
      fwd_addr  = addr[gnt_idx];
      fwd_wdata = wdata[gnt_idx];
   end

   assign rd_data = s_rdata[rd_src_q];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ptr_q     <= '0;
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= gnt_any && (fwd_op == OP_READ);
         if (gnt_any) begin
            ptr_q <= tile_id_t'((int'(gnt_idx) + 1) % `DM_NUM_TILES);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (gnt_any) begin
         rd_idx_q <= gnt_idx;
         rd_src_q <= fwd_dst;
      end
   end

   a_gnt_ptr: assert property (@(posedge clk) disable iff (!rst_n_i)
      req[ptr_q] |-> gnt[ptr_q])
      else $error("requesting tile at the pointer was passed over");

   a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      (gnt & ~req) == '0)
      else $error("grant given to a tile without a request");

endmodule

`default_nettype wire

/* rtl/compute_tile_dm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module compute_tile_dm
   import dm_pkg::*;
(
   input  wire            clk,
   input  wire            rst_n_i,

   // Host command port.
   input  wire            cmd_valid_i,
   output logic           cmd_ready_o,
   input  wire bus_op_e   cmd_op_i,
   input  wire tile_id_t  cmd_dst_i,
   input  wire mem_addr_t cmd_addr_i,
   input  wire word_t     cmd_wdata_i,
   output logic           resp_valid_o,
   output word_t          resp_rdata_o,

   // Shared memory bus.
   dm_bus_if.master       bus_m,
   dm_bus_if.slave        bus_s
);

   tile_state_e state_q;
   logic        accept;
   bus_op_e     op_q;
   tile_id_t    dst_q;
   mem_addr_t   addr_q;
   word_t       wdata_q;

   word_t       mem_q [`DM_MEM_WORDS];
   word_t       s_rdata_q;

   // --------------------------------------------------
   // Command FSM
   // --------------------------------------------------
   assign cmd_ready_o = (state_q == ST_IDLE);
   assign accept      = cmd_valid_i && cmd_ready_o;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= 1'b0;  // Single-cycle pulse.
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (bus_m.gnt) begin
                  // Writes finish with the grant.
                  state_q <= (op_q == OP_READ) ? ST_WAIT : ST_IDLE;
               end
            end
            ST_WAIT: begin
               if (bus_m.rvalid) begin
                  state_q      <= ST_IDLE;
                  resp_valid_o <= 1'b1;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q    <= cmd_op_i;
         dst_q   <= cmd_dst_i;
         addr_q  <= cmd_addr_i;
         wdata_q <= cmd_wdata_i;
      end
      if (state_q == ST_WAIT && bus_m.rvalid) begin
         resp_rdata_o <= bus_m.rdata;
      end
   end

   assign bus_m.req   = (state_q == ST_REQ);
   assign bus_m.op    = op_q;
   assign bus_m.dst   = dst_q;
   assign bus_m.addr  = addr_q;
   assign bus_m.wdata = wdata_q;

   // --------------------------------------------------
   // Local memory, served to any tile
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (bus_s.s_stb) begin
         if (bus_s.s_op == OP_WRITE) begin
            mem_q[bus_s.s_addr] <= bus_s.s_wdata;
         end else begin
            s_rdata_q <= mem_q[bus_s.s_addr];  // Returned next cycle.
         end
      end
   end

   assign bus_s.s_rdata = s_rdata_q;

   a_accept_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
      accept |-> (!bus_m.gnt && !bus_m.rvalid))
      else $error("command taken while a bus access is in flight");

   a_rd_return: assert property (@(posedge clk) disable iff (!rst_n_i)
      (bus_m.gnt && bus_m.op == OP_READ) |=> bus_m.rvalid)
      else $error("read grant not followed by read data");

endmodule

`default_nettype wire

/* rtl/system_2x2_dm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module system_2x2_dm
   import dm_pkg::*;
(
   input  wire                                clk,
   input  wire                                rst_n_i,

   // --------------------------------------------------
   // Host command ports, one slice per tile
   // --------------------------------------------------
   input  wire [`DM_NUM_TILES-1:0]            cmd_valid_i,
   output logic [`DM_NUM_TILES-1:0]           cmd_ready_o,
   input  wire bus_op_e [`DM_NUM_TILES-1:0]   cmd_op_i,
   input  wire tile_id_t [`DM_NUM_TILES-1:0]  cmd_dst_i,
   input  wire mem_addr_t [`DM_NUM_TILES-1:0] cmd_addr_i,
   input  wire word_t [`DM_NUM_TILES-1:0]     cmd_wdata_i,

   // Read responses.
   output logic [`DM_NUM_TILES-1:0]           resp_valid_o,
   output word_t [`DM_NUM_TILES-1:0]          resp_rdata_o
);

   // One bus port per tile, in place of the mesh.
   dm_bus_if bus [`DM_NUM_TILES-1:0] ();

   // --------------------------------------------------
   // Compute tiles
   // --------------------------------------------------
   genvar i;
   generate
      for (i = 0; i < `DM_NUM_TILES; i = i + 1) begin : gen_ct
         compute_tile_dm u_ct (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .cmd_valid_i  (cmd_valid_i[i]),
            .cmd_ready_o  (cmd_ready_o[i]),
            .cmd_op_i     (cmd_op_i[i]),
            .cmd_dst_i    (cmd_dst_i[i]),
            .cmd_addr_i   (cmd_addr_i[i]),
            .cmd_wdata_i  (cmd_wdata_i[i]),
            .resp_valid_o (resp_valid_o[i]),
            .resp_rdata_o (resp_rdata_o[i]),
            .bus_m        (bus[i]),   // Tile as requester.
            .bus_s        (bus[i])    // Tile memory as target.
         );
      end
   endgenerate

   // --------------------------------------------------
   // Shared bus arbitration
   // --------------------------------------------------
   mem_bus_arbiter u_arb (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_if  (bus)
   );

endmodule

`default_nettype wire

/* tb/tb_system_2x2_dm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module tb_system_2x2_dm
   import dm_pkg::*;
();

   localparam int NT            = `DM_NUM_TILES;
   localparam int RESET_CYCLES  = 16;
   localparam int NUM_RANDOM    = 200;
   localparam int DIRECTED_CMDS = 18;  // Own, remote and contention commands.
   localparam int CMD_TIMEOUT   = 20;
   localparam int LAT_WR        = 2;   // Falling edges from accept to ready.
   localparam int LAT_RD        = 3;
   localparam int CONTEND_EXTRA = 3;   // At most three other grants first.
   localparam int MAX_CYCLES    = RESET_CYCLES + (NUM_RANDOM + DIRECTED_CMDS) * CMD_TIMEOUT;

   logic               clk;
   logic               rst_n_i;
   logic [NT-1:0]      cmd_valid_i;
   logic [NT-1:0]      cmd_ready_o;
   bus_op_e [NT-1:0]   cmd_op_i;
   tile_id_t [NT-1:0]  cmd_dst_i;
   mem_addr_t [NT-1:0] cmd_addr_i;
   word_t [NT-1:0]     cmd_wdata_i;
   logic [NT-1:0]      resp_valid_o;
   word_t [NT-1:0]     resp_rdata_o;

   word_t   ref_mem     [NT][`DM_MEM_WORDS];
   bit      ref_written [NT][`DM_MEM_WORDS];
   bit      pending     [NT];  // Accepted, not yet complete.
   int      lat_cnt     [NT];
   bus_op_e pend_op     [NT];
   word_t   exp_word    [NT];
   int      busy_cnt    [NT];
   int      cycle_cnt;
   bit      exact_timing;     // Uncontended phases only.

   system_2x2_dm u_system_2x2_dm (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_op_i     (cmd_op_i),
      .cmd_dst_i    (cmd_dst_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_wdata_i  (cmd_wdata_i),
      .resp_valid_o (resp_valid_o),
      .resp_rdata_o (resp_rdata_o)
   );

   always #10 clk = ~clk;  // 20 ns period.

   // --------------------------------------------------
   // Reference model and compare tasks
   // --------------------------------------------------
   function automatic word_t ref_access(bus_op_e op, tile_id_t d, mem_addr_t a, word_t wd);
      if (op == OP_WRITE) begin
         ref_mem[d][a]     = wd;
         ref_written[d][a] = 1'b1;
      end
      return ref_mem[d][a];
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_word(string sig, tile_id_t t, word_t got, word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR %s[%0d]: got 0x%h, expected 0x%h", sig, t, got, exp));
      end
   endtask

   task automatic check_ready(string sig, tile_id_t t, bit got, bit exp);
      if (got != exp) begin
         fail_run($sformatf("ERROR %s[%0d]: got 0x%h, expected 0x%h", sig, t, got, exp));
      end
   endtask

   // --------------------------------------------------
   // Compare process
   // --------------------------------------------------
   always begin
      bit rd_done;
      int lat;
      @(posedge clk);
      for (int t = 0; t < NT; t++) begin
         if (rst_n_i && cmd_valid_i[t] && cmd_ready_o[t]) begin
            pending[t]  = 1'b1;
            lat_cnt[t]  = 0;
            pend_op[t]  = cmd_op_i[t];
            exp_word[t] = ref_access(cmd_op_i[t], cmd_dst_i[t], cmd_addr_i[t], cmd_wdata_i[t]);
         end
      end
      @(negedge clk);
      for (int t = 0; t < NT; t++) begin
         rd_done = 1'b0;
         if (pending[t]) begin
            lat_cnt[t]++;
            lat = (pend_op[t] == OP_WRITE) ? LAT_WR : LAT_RD;
            if (exact_timing || lat_cnt[t] < lat) begin
               check_ready("cmd_ready_o", tile_id_t'(t), cmd_ready_o[t], lat_cnt[t] == lat);
            end else if (lat_cnt[t] > lat + CONTEND_EXTRA) begin
               fail_run($sformatf("Tile %0d needed %0d cycles, beyond the contended bound",
                                  t, lat_cnt[t]));
            end
            if (cmd_ready_o[t]) begin
               pending[t] = 1'b0;
               if (pend_op[t] == OP_READ) begin
                  rd_done = 1'b1;
                  check_word("resp_rdata_o", tile_id_t'(t), resp_rdata_o[t], exp_word[t]);
               end
            end
         end
         if (rst_n_i) begin
            check_ready("resp_valid_o", tile_id_t'(t), resp_valid_o[t], rd_done);
         end
      end
   end

   // --------------------------------------------------
   // Timeouts
   // --------------------------------------------------
   always @(posedge clk) begin
      for (int t = 0; t < NT; t++) begin
         busy_cnt[t] = (rst_n_i && !cmd_ready_o[t]) ? busy_cnt[t] + 1 : 0;
         if (busy_cnt[t] > CMD_TIMEOUT) begin
            fail_run($sformatf("Tile %0d command did not complete within %0d cycles",
                               t, CMD_TIMEOUT));
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
         fail_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   // --------------------------------------------------
   // Stimulus helpers, all used on the falling edge
   // --------------------------------------------------
   task automatic step();
      @(negedge clk);
      cmd_valid_i = '0;  // Any raised valid was taken at the last rising edge.
   endtask

   function automatic bit tile_idle(int t);
      return cmd_ready_o[t] && !cmd_valid_i[t];
   endfunction

   task automatic wait_idle(int t);
      while (!tile_idle(t)) step();
   endtask

   task automatic wait_all_idle();
      for (int t = 0; t < NT; t++) wait_idle(t);
   endtask

   // A location already targeted by another tile's live command.
   function automatic bit loc_busy(int t, tile_id_t d, mem_addr_t a);
      for (int u = 0; u < NT; u++) begin
         if (u != t && (cmd_valid_i[u] || !cmd_ready_o[u]) &&
             cmd_dst_i[u] == d && cmd_addr_i[u] == a) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic issue(int t, bus_op_e op, tile_id_t d, mem_addr_t a, word_t wd);
      cmd_op_i[t]    = op;
      cmd_dst_i[t]   = d;
      cmd_addr_i[t]  = a;
      cmd_wdata_i[t] = wd;
      cmd_valid_i[t] = 1'b1;
   endtask

   task automatic run_one(int t, bus_op_e op, tile_id_t d, mem_addr_t a, word_t wd);
      wait_idle(t);
      issue(t, op, d, a, wd);
      step();
      wait_idle(t);
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      tile_id_t  d;
      mem_addr_t a;
      word_t     w;
      bus_op_e   op;
      int        issued;
      void'($urandom(32'heec2bd5e));
      clk          = 1'b0;
      rst_n_i      = 1'b0;
      cmd_valid_i  = '0;
      cmd_dst_i    = '0;
      cmd_addr_i   = '0;
      cmd_wdata_i  = '0;
      cycle_cnt    = 0;
      exact_timing = 1'b1;
      for (int t = 0; t < NT; t++) begin
         cmd_op_i[t] = OP_READ;
         pending[t]  = 1'b0;
         busy_cnt[t] = 0;
         for (int k = 0; k < `DM_MEM_WORDS; k++) ref_written[t][k] = 1'b0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      step();
      for (int t = 0; t < NT; t++) begin
         check_ready("cmd_ready_o", tile_id_t'(t), cmd_ready_o[t], 1'b1);
         check_ready("resp_valid_o", tile_id_t'(t), resp_valid_o[t], 1'b0);
      end

      // Own memory write and read back.
      a = mem_addr_t'($urandom_range(0, `DM_MEM_WORDS - 1));
      w = word_t'($urandom());
      run_one(0, OP_WRITE, tile_id_t'(0), a, w);
      run_one(0, OP_READ, tile_id_t'(0), a, '0);

      // Remote write, read by a third tile.
      for (int t = 0; t < NT; t++) begin
         a = mem_addr_t'($urandom_range(0, `DM_MEM_WORDS - 1));
         w = word_t'($urandom());
         run_one(t, OP_WRITE, tile_id_t'((t + 1) % NT), a, w);
         run_one((t + 2) % NT, OP_READ, tile_id_t'((t + 1) % NT), a, '0);
      end

      // All tiles at once.
      wait_all_idle();
      exact_timing = 1'b0;
      for (int t = 0; t < NT; t++) begin
         issue(t, OP_WRITE, tile_id_t'((t + 1) % NT), mem_addr_t'(40 + t), word_t'($urandom()));
      end
      step();
      wait_all_idle();
      for (int t = 0; t < NT; t++) begin
         issue(t, OP_READ, tile_id_t'((t + 2) % NT), mem_addr_t'(40 + (t + 1) % NT), '0);
      end
      step();
      wait_all_idle();

      // Random traffic, reads only from written words.
      issued = 0;
      while (issued < NUM_RANDOM) begin
         step();
         for (int t = 0; t < NT; t++) begin
            if (issued < NUM_RANDOM && tile_idle(t) && $urandom_range(0, 1) == 1) begin
               d = tile_id_t'($urandom_range(0, NT - 1));
               a = mem_addr_t'($urandom_range(0, `DM_MEM_WORDS - 1));
               if (!loc_busy(t, d, a)) begin
                  op = (ref_written[d][a] && $urandom_range(0, 1) == 1) ? OP_READ : OP_WRITE;
                  issue(t, op, d, a, word_t'($urandom()));
                  issued++;
               end
            end
         end
      end
      step();
      wait_all_idle();
      repeat (2) step();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* system_2x2_dm.f */
+incdir+rtl
rtl/dm_pkg.sv
rtl/dm_bus_if.sv
rtl/mem_bus_arbiter.sv
rtl/compute_tile_dm.sv
rtl/system_2x2_dm.sv
tb/tb_system_2x2_dm.sv

/* Makefile */
# Verilator build and run for the 2x2 distributed-memory system.

VERILATOR ?= verilator
TOP       ?= tb_system_2x2_dm
FILELIST  ?= system_2x2_dm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/dm_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
